/* source/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// architectural state after reset
`define CPU_RESET_PC 16'hC000

// I set, bit 5 always reads as one
`define CPU_RESET_STATUS 8'h24

// request queue entries, also the input credits held by the source
`define CPU_REQ_FIFO_DEPTH 4

// commit credits held by the core after reset
`define CPU_OUT_CREDITS 2

`endif

/* source/cpu_arch_pkg.sv */
`default_nettype none

package cpu_arch_pkg;

    // NV-BDIZC, msb first
    typedef struct packed {
        logic n;
        logic v;
        logic one;
        logic b;
        logic d;
        logic i;
        logic z;
        logic c;
    } status_flags_t;

    // raw byte for PLP, flag view for everything else
    typedef union packed {
        logic [7:0]    raw;
        status_flags_t flags;
    } status_u;

    // register source and destination
    typedef enum logic [1:0] {
        REG_A = 2'd0,
        REG_X = 2'd1,
        REG_Y = 2'd2
    } reg_sel_e;

    // flag tested by a branch
    typedef enum logic [1:0] {
        BR_C = 2'd0,
        BR_Z = 2'd1,
        BR_N = 2'd2,
        BR_V = 2'd3
    } branch_flag_e;

endpackage : cpu_arch_pkg

`default_nettype wire

/* source/exec_if_pkg.sv */
`default_nettype none

package exec_if_pkg;
    import cpu_arch_pkg::*;

    typedef enum logic [4:0] {
        OP_ADC, OP_SBC, OP_AND, OP_ORA,
        OP_EOR, OP_CMP, OP_LD,  OP_SEC,
        OP_CLC, OP_SEI, OP_CLI, OP_SED,
        OP_CLD, OP_CLV, OP_PLP, OP_BR
    } exec_op_e;

    // one two-byte instruction, operand is the second byte
    typedef struct packed {
        exec_op_e     op;
        reg_sel_e     reg_sel;
        branch_flag_e br_flag;
        logic         br_inv;
        logic [7:0]   operand;
    } exec_req_t;

    typedef struct packed {
        logic [7:0] value;
        logic       wr_reg;
        status_u    status;
    } alu_res_t;

    typedef struct packed {
        logic        taken;
        logic [15:0] next_pc;
    } branch_res_t;

    typedef struct packed {
        logic [15:0] pc;
        logic [7:0]  a;
        logic [7:0]  x;
        logic [7:0]  y;
        status_u     status;
    } arch_state_t;

    // state after the instruction
    typedef struct packed {
        arch_state_t state;
        logic        taken;
    } commit_t;

endpackage : exec_if_pkg

`default_nettype wire

/* source/req_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module req_fifo import exec_if_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset_active,
    input  logic      i_push,
    input  exec_req_t i_push_data,
    input  logic      i_pop,
    output exec_req_t o_head,
    output logic      o_head_valid,
    output logic      o_credit
);

    localparam int DEPTH = `CPU_REQ_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    exec_req_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // source never pushes without a credit, so no full check
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset_active) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(i_push) - CNT_W'(i_pop);
            // one credit back per popped entry
            o_credit <= i_pop;
        end
    end

    assign o_head       = mem[rd_ptr];
    assign o_head_valid = (count != '0);

endmodule : req_fifo

`default_nettype wire

/* source/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit import cpu_arch_pkg::*, exec_if_pkg::*; (
    input  exec_req_t   i_req,
    input  arch_state_t i_state,
    output alu_res_t    o_res
);

    logic [7:0] src;
    logic [7:0] opb;
    logic       cin;
    logic [8:0] sum;
    logic       ovf;
    logic       nz_upd;

    always_comb begin
        case (i_req.reg_sel)
            REG_X:   src = i_state.x;
            REG_Y:   src = i_state.y;
            default: src = i_state.a;
        endcase
    end

    // one adder serves ADC, SBC and CMP
    always_comb begin
        opb = (i_req.op == OP_ADC) ? i_req.operand : ~i_req.operand;
        cin = (i_req.op == OP_CMP) ? 1'b1 : i_state.status.flags.c;
        sum = {1'b0, src} + {1'b0, opb} + {8'd0, cin};
        // same input signs, different result sign
        ovf = (src[7] == opb[7]) && (sum[7] != src[7]);
    end

    always_comb begin
        o_res.value  = sum[7:0];
        o_res.wr_reg = 1'b0;
        o_res.status = i_state.status;
        nz_upd       = 1'b1;

        case (i_req.op)
            OP_ADC, OP_SBC: begin
                o_res.wr_reg         = 1'b1;
                o_res.status.flags.c = sum[8];
                o_res.status.flags.v = ovf;
            end
            OP_AND: begin
                o_res.value  = src & i_req.operand;
                o_res.wr_reg = 1'b1;
            end
            OP_ORA: begin
                o_res.value  = src | i_req.operand;
                o_res.wr_reg = 1'b1;
            end
            OP_EOR: begin
                o_res.value  = src ^ i_req.operand;
                o_res.wr_reg = 1'b1;
            end
            OP_LD: begin
                o_res.value  = i_req.operand;
                o_res.wr_reg = 1'b1;
            end
            // no borrow means src >= operand
            OP_CMP: o_res.status.flags.c = sum[8];
            OP_SEC: begin
                o_res.status.flags.c = 1'b1;
                nz_upd               = 1'b0;
            end
            OP_CLC: begin
                o_res.status.flags.c = 1'b0;
                nz_upd               = 1'b0;
            end
            OP_SEI: begin
                o_res.status.flags.i = 1'b1;
                nz_upd               = 1'b0;
            end
            OP_CLI: begin
                o_res.status.flags.i = 1'b0;
                nz_upd               = 1'b0;
            end
            OP_SED: begin
                o_res.status.flags.d = 1'b1;
                nz_upd               = 1'b0;
            end
            OP_CLD: begin
                o_res.status.flags.d = 1'b0;
                nz_upd               = 1'b0;
            end
            OP_CLV: begin
                o_res.status.flags.v = 1'b0;
                nz_upd               = 1'b0;
            end
            OP_PLP: begin
                // pulled byte, B never stored, bit 5 reads as one
                o_res.status.raw       = i_req.operand;
                o_res.status.flags.b   = 1'b0;
                o_res.status.flags.one = 1'b1;
                nz_upd                 = 1'b0;
            end
            default: nz_upd = 1'b0;
        endcase

        if (nz_upd) begin
            o_res.status.flags.n = o_res.value[7];
            o_res.status.flags.z = (o_res.value == 8'h00);
        end
    end

endmodule : alu_unit

`default_nettype wire

/* source/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit import cpu_arch_pkg::*, exec_if_pkg::*; (
    input  exec_req_t   i_req,
    input  arch_state_t i_state,
    output branch_res_t o_res
);

    logic        flag;
    logic [15:0] disp;

    always_comb begin
        case (i_req.br_flag)
            BR_C:    flag = i_state.status.flags.c;
            BR_Z:    flag = i_state.status.flags.z;
            BR_N:    flag = i_state.status.flags.n;
            default: flag = i_state.status.flags.v;
        endcase
    end

    // signed offset relative to the next instruction
    assign disp = {{8{i_req.operand[7]}}, i_req.operand};

    always_comb begin
        o_res.taken   = (i_req.op == OP_BR) && (flag ^ i_req.br_inv);
        o_res.next_pc = i_state.pc + 16'd2;
        if (o_res.taken) begin
            o_res.next_pc = i_state.pc + 16'd2 + disp;
        end
    end

endmodule : branch_unit

`default_nettype wire

/* source/arch_commit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module arch_commit import cpu_arch_pkg::*, exec_if_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset_active,
    input  exec_req_t   i_head,
    input  logic        i_head_valid,
    input  alu_res_t    i_alu,
    input  branch_res_t i_branch,
    input  logic        i_commit_credit,
    output arch_state_t o_state,
    output logic        o_pop,
    output commit_t     o_commit,
    output logic        o_commit_valid
);

    localparam int CRED_W = $clog2(`CPU_OUT_CREDITS + 1);

    arch_state_t      state_q;
    arch_state_t      state_d;
    logic [CRED_W-1:0] credits;
    logic             exec;

    ////////////////////////////////////////////////////////////////////////////
    // execute decision

    // stall on an empty queue or with no commit credit left
    assign exec  = i_head_valid && (credits != '0);
    assign o_pop = exec;

    ////////////////////////////////////////////////////////////////////////////
    // next architectural state

    always_comb begin
        state_d        = state_q;
        state_d.pc     = i_branch.next_pc;
        state_d.status = i_alu.status;
        if (i_alu.wr_reg) begin
            case (i_head.reg_sel)
                REG_X:   state_d.x = i_alu.value;
                REG_Y:   state_d.y = i_alu.value;
                default: state_d.a = i_alu.value;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers

    always_ff @(posedge i_clk) begin
        if (i_reset_active) begin
            state_q.pc         <= `CPU_RESET_PC;
            state_q.a          <= 8'h00;
            state_q.x          <= 8'h00;
            state_q.y          <= 8'h00;
            state_q.status.raw <= `CPU_RESET_STATUS;
        end else if (exec) begin
            state_q <= state_d;
        end
    end

    // credits come back from the sink at any time
    always_ff @(posedge i_clk) begin
        if (i_reset_active) begin
            credits <= CRED_W'(`CPU_OUT_CREDITS);
        end else begin
            credits <= credits + CRED_W'(i_commit_credit) - CRED_W'(exec);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset_active) begin
            o_commit_valid <= 1'b0;
        end else begin
            o_commit_valid <= exec;
        end
    end

    // commit record, qualified by o_commit_valid
    always_ff @(posedge i_clk) begin
        if (exec) begin
            o_commit.state <= state_d;
            o_commit.taken <= i_branch.taken;
        end
    end

    assign o_state = state_q;

endmodule : arch_commit

`default_nettype wire

/* source/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top import exec_if_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset_active,
    input  logic      i_req_valid,
    input  exec_req_t i_req,
    output logic      o_req_credit,
    output logic      o_commit_valid,
    output commit_t   o_commit,
    input  logic      i_commit_credit
);

    exec_req_t   head;
    logic        head_valid;
    logic        pop;
    arch_state_t state;
    alu_res_t    alu_res;
    branch_res_t br_res;

    // request queue, one credit back per pop
    req_fifo u_req_fifo (
        .i_clk          (i_clk),
        .i_reset_active (i_reset_active),
        .i_push         (i_req_valid),
        .i_push_data    (i_req),
        .i_pop          (pop),
        .o_head         (head),
        .o_head_valid   (head_valid),
        .o_credit       (o_req_credit)
    );

    // both units see the same head and state
    alu_unit u_alu (
        .i_req   (head),
        .i_state (state),
        .o_res   (alu_res)
    );

    branch_unit u_branch (
        .i_req   (head),
        .i_state (state),
        .o_res   (br_res)
    );

    arch_commit u_commit (
        .i_clk           (i_clk),
        .i_reset_active  (i_reset_active),
        .i_head          (head),
        .i_head_valid    (head_valid),
        .i_alu           (alu_res),
        .i_branch        (br_res),
        .i_commit_credit (i_commit_credit),
        .o_state         (state),
        .o_pop           (pop),
        .o_commit        (o_commit),
        .o_commit_valid  (o_commit_valid)
    );

endmodule : exec_top

`default_nettype wire

/* testbench/tb_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module tb_exec_top import cpu_arch_pkg::*, exec_if_pkg::*; ();

    localparam int TIMEOUT     = 200;
    localparam int HOLD_CYCLES = 20;

    logic      clk;
    logic      reset_active;
    logic      req_valid;
    exec_req_t req;
    logic      req_credit;
    logic      commit_valid;
    commit_t   commit;
    logic      commit_credit;

    string       names [$];
    exec_req_t   reqs [$];
    commit_t     exps [$];
    int          errors;
    int          sent;
    int          returned;
    int          credited;
    int          rx_count;
    logic [31:0] lcg_state;

    // reference copy of the architectural state
    logic [15:0] m_pc;
    logic [7:0]  m_a;
    logic [7:0]  m_x;
    logic [7:0]  m_y;
    logic [7:0]  m_p;

    exec_top dut0 (
        .i_clk           (clk),
        .i_reset_active  (reset_active),
        .i_req_valid     (req_valid),
        .i_req           (req),
        .o_req_credit    (req_credit),
        .o_commit_valid  (commit_valid),
        .o_commit        (commit),
        .i_commit_credit (commit_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model with status bits NV1BDIZC

    task automatic model_step(input exec_req_t r, output commit_t c);
        logic [7:0] src;
        logic [7:0] res;
        logic [8:0] wide;
        int         sres;
        logic       wr;
        logic       nz;
        logic       flag;
        logic       taken;
        src = (r.reg_sel == REG_X) ? m_x : ((r.reg_sel == REG_Y) ? m_y : m_a);
        case (r.br_flag)
            BR_C:    flag = m_p[0];
            BR_Z:    flag = m_p[1];
            BR_N:    flag = m_p[7];
            default: flag = m_p[6];
        endcase
        taken = (r.op == OP_BR) && (flag != r.br_inv);
        res   = src;
        wr    = 1'b0;
        nz    = 1'b1;
        case (r.op)
            OP_ADC: begin
                wide   = {1'b0, src} + {1'b0, r.operand} + {8'd0, m_p[0]};
                sres   = int'($signed(src)) + int'($signed(r.operand)) + int'(m_p[0]);
                res    = wide[7:0];
                wr     = 1'b1;
                m_p[0] = wide[8];
                // signed sum outside the 8-bit range
                m_p[6] = (sres > 127) || (sres < -128);
            end
            OP_SBC: begin
                // borrow in is the inverse of carry
                wide   = {1'b0, src} - {1'b0, r.operand} - {8'd0, ~m_p[0]};
                res    = wide[7:0];
                wr     = 1'b1;
                m_p[0] = ~wide[8];
                m_p[6] = (src[7] != r.operand[7]) && (res[7] != src[7]);
            end
            OP_CMP: begin
                res    = src - r.operand;
                m_p[0] = (src >= r.operand);
            end
            OP_AND: begin
                res = src & r.operand;
                wr  = 1'b1;
            end
            OP_ORA: begin
                res = src | r.operand;
                wr  = 1'b1;
            end
            OP_EOR: begin
                res = src ^ r.operand;
                wr  = 1'b1;
            end
            OP_LD: begin
                res = r.operand;
                wr  = 1'b1;
            end
            OP_SEC: m_p[0] = 1'b1;
            OP_CLC: m_p[0] = 1'b0;
            OP_SEI: m_p[2] = 1'b1;
            OP_CLI: m_p[2] = 1'b0;
            OP_SED: m_p[3] = 1'b1;
            OP_CLD: m_p[3] = 1'b0;
            OP_CLV: m_p[6] = 1'b0;
            OP_PLP: m_p = (r.operand & 8'hEF) | 8'h20;
            default: ;
        endcase
        if (r.op inside {OP_ADC, OP_SBC, OP_CMP, OP_AND, OP_ORA, OP_EOR, OP_LD}) begin
            m_p[7] = res[7];
            m_p[1] = (res == 8'h00);
        end
        if (wr) begin
            case (r.reg_sel)
                REG_X:   m_x = res;
                REG_Y:   m_y = res;
                default: m_a = res;
            endcase
        end
        m_pc = m_pc + 16'd2 + (taken ? {{8{r.operand[7]}}, r.operand} : 16'd0);
        c.state.pc         = m_pc;
        c.state.a          = m_a;
        c.state.x          = m_x;
        c.state.y          = m_y;
        c.state.status.raw = m_p;
        c.taken            = taken;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table

    task automatic add_entry(input string name, input exec_op_e op, input reg_sel_e rs,
                             input branch_flag_e bf, input logic inv, input logic [7:0] opnd);
        exec_req_t r;
        commit_t   c;
        r.op      = op;
        r.reg_sel = rs;
        r.br_flag = bf;
        r.br_inv  = inv;
        r.operand = opnd;
        model_step(r, c);
        names.push_back(name);
        reqs.push_back(r);
        exps.push_back(c);
    endtask

    task automatic build_table();
        m_pc = `CPU_RESET_PC;
        m_a  = 8'h00;
        m_x  = 8'h00;
        m_y  = 8'h00;
        m_p  = `CPU_RESET_STATUS;
        add_entry("clc_reset",    OP_CLC, REG_A, BR_C, 1'b0, 8'h00);
        add_entry("ld_a_7f",      OP_LD,  REG_A, BR_C, 1'b0, 8'h7F);
        add_entry("adc_a_ovf",    OP_ADC, REG_A, BR_C, 1'b0, 8'h01);
        add_entry("adc_a_cout",   OP_ADC, REG_A, BR_C, 1'b0, 8'h80);
        add_entry("adc_a_cin",    OP_ADC, REG_A, BR_C, 1'b0, 8'h05);
        add_entry("ld_x_00",      OP_LD,  REG_X, BR_C, 1'b0, 8'h00);
        add_entry("sec_for_sbc",  OP_SEC, REG_A, BR_C, 1'b0, 8'h00);
        add_entry("sbc_x_borrow", OP_SBC, REG_X, BR_C, 1'b0, 8'h01);
        add_entry("sbc_x_ovf",    OP_SBC, REG_X, BR_C, 1'b0, 8'h7F);
        add_entry("ld_y_ff",      OP_LD,  REG_Y, BR_C, 1'b0, 8'hFF);
        add_entry("adc_y_wrap",   OP_ADC, REG_Y, BR_C, 1'b0, 8'h01);
        add_entry("sbc_y",        OP_SBC, REG_Y, BR_C, 1'b0, 8'h02);
        add_entry("ld_a_f0",      OP_LD,  REG_A, BR_C, 1'b0, 8'hF0);
        add_entry("and_a",        OP_AND, REG_A, BR_C, 1'b0, 8'h3C);
        add_entry("ora_a",        OP_ORA, REG_A, BR_C, 1'b0, 8'h0F);
        add_entry("eor_a",        OP_EOR, REG_A, BR_C, 1'b0, 8'hFF);
        add_entry("cmp_a_gt",     OP_CMP, REG_A, BR_C, 1'b0, 8'h10);
        add_entry("cmp_a_eq",     OP_CMP, REG_A, BR_C, 1'b0, 8'hC0);
        add_entry("cmp_a_lt",     OP_CMP, REG_A, BR_C, 1'b0, 8'hD0);
        add_entry("sec",          OP_SEC, REG_A, BR_C, 1'b0, 8'h00);
        add_entry("clc",          OP_CLC, REG_A, BR_C, 1'b0, 8'h00);
        add_entry("sei",          OP_SEI, REG_A, BR_C, 1'b0, 8'h00);
        add_entry("cli",          OP_CLI, REG_A, BR_C, 1'b0, 8'h00);
        add_entry("sed",          OP_SED, REG_A, BR_C, 1'b0, 8'h00);
        add_entry("cld",          OP_CLD, REG_A, BR_C, 1'b0, 8'h00);
        add_entry("plp_v",        OP_PLP, REG_A, BR_C, 1'b0, 8'h40);
        add_entry("clv",          OP_CLV, REG_A, BR_C, 1'b0, 8'h00);
        add_entry("plp_ff",       OP_PLP, REG_A, BR_C, 1'b0, 8'hFF);
        add_entry("plp_00",       OP_PLP, REG_A, BR_C, 1'b0, 8'h00);
        // all flags clear with a forward offset
        for (int f = 0; f < 4; f++) begin
            for (int inv = 0; inv < 2; inv++) begin
                add_entry($sformatf("br_clr_f%0d_inv%0d", f, inv), OP_BR, REG_A,
                          branch_flag_e'(f), inv[0], 8'h10);
            end
        end
        add_entry("plp_c3",       OP_PLP, REG_A, BR_C, 1'b0, 8'hC3);
        // all flags set with a backward offset
        for (int f = 0; f < 4; f++) begin
            for (int inv = 0; inv < 2; inv++) begin
                add_entry($sformatf("br_set_f%0d_inv%0d", f, inv), OP_BR, REG_A,
                          branch_flag_e'(f), inv[0], 8'hF0);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run control

    task automatic finish_run();
        $display("errors: %0d, commits checked: %0d of %0d", errors, rx_count, reqs.size());
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("Timed out waiting for %s.", what);
        finish_run();
    endtask

    task automatic send_requests();
        int waited;
        foreach (reqs[i]) begin
            waited = 0;
            while (sent - returned >= `CPU_REQ_FIFO_DEPTH && waited < TIMEOUT) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (sent - returned >= `CPU_REQ_FIFO_DEPTH) begin
                abort_on_timeout($sformatf("an input credit for entry %s", names[i]));
            end else begin
                req_valid = 1'b1;
                req       = reqs[i];
                sent++;
                @(posedge clk);
                #1;
                req_valid = 1'b0;
            end
        end
    endtask

    task automatic receive_commits();
        int waited;
        foreach (exps[i]) begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!commit_valid && waited < TIMEOUT);
            if (!commit_valid) begin
                abort_on_timeout($sformatf("the commit of entry %s", names[i]));
            end else begin
                assert (commit === exps[i]) else begin
                    errors++;
                    $display("[ERROR] %s: expected %h, actual %h", names[i], exps[i], commit);
                end
                rx_count++;
                assert (rx_count <= `CPU_OUT_CREDITS + credited) else begin
                    errors++;
                    $display("Commit %0d arrived without a commit credit.", rx_count);
                end
            end
        end
    endtask

    task automatic return_credits();
        int waited;
        int gap;
        // no credits at first so the core must stall
        repeat (HOLD_CYCLES) @(posedge clk);
        assert (rx_count == `CPU_OUT_CREDITS) else begin
            errors++;
            $display("[ERROR] backpressure: expected %0d, actual %0d",
                     `CPU_OUT_CREDITS, rx_count);
        end
        while (credited < exps.size()) begin
            waited = 0;
            while (rx_count <= credited && waited < TIMEOUT) begin
                @(posedge clk);
                waited++;
            end
            if (rx_count <= credited) begin
                abort_on_timeout($sformatf("commit %0d before returning its credit", credited));
            end else begin
                lcg_state = lcg_next(lcg_state);
                gap       = lcg_state[29:28];
                repeat (gap + 1) @(posedge clk);
                #1;
                commit_credit = 1'b1;
                credited++;
                @(posedge clk);
                #1;
                commit_credit = 1'b0;
            end
        end
    endtask

    // input credits never outnumber accepted requests
    always @(posedge clk) begin
        if (!reset_active && req_credit) begin
            returned++;
            assert (returned <= sent) else begin
                errors++;
                $display("More input credits came back than requests were sent.");
            end
        end
    end

    initial begin
        int waited;
        reset_active  = 1'b1;
        req_valid     = 1'b0;
        req           = '0;
        commit_credit = 1'b0;
        errors        = 0;
        sent          = 0;
        returned      = 0;
        credited      = 0;
        rx_count      = 0;
        lcg_state     = 32'h95a40a4c;
        build_table();
        repeat (5) @(posedge clk);
        #1;
        reset_active = 1'b0;
        assert (!commit_valid && !req_credit) else begin
            errors++;
            $display("Commit valid or request credit was high right after reset.");
        end
        fork
            send_requests();
            receive_commits();
            return_credits();
        join
        waited = 0;
        while (returned != sent && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        assert (`CPU_REQ_FIFO_DEPTH - sent + returned == `CPU_REQ_FIFO_DEPTH) else begin
            errors++;
            $display("The last input credits never came back, the source holds %0d of %0d.",
                     `CPU_REQ_FIFO_DEPTH - sent + returned, `CPU_REQ_FIFO_DEPTH);
        end
        finish_run();
    end

endmodule : tb_exec_top

`default_nettype wire

/* compile.f */
+incdir+source
source/cpu_arch_pkg.sv
source/exec_if_pkg.sv
source/req_fifo.sv
source/alu_unit.sv
source/branch_unit.sv
source/arch_commit.sv
source/exec_top.sv
testbench/tb_exec_top.sv

/* Bender.yml */
package:
  name: exec_core

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_arch_pkg.sv
      - source/exec_if_pkg.sv
      - source/req_fifo.sv
      - source/alu_unit.sv
      - source/branch_unit.sv
      - source/arch_commit.sv
      - source/exec_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_exec_top.sv
